// ==== common/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

// ----------------------------------------------------------------------
// widths

localparam int unsigned CSR_DATA_W = 32;
localparam int unsigned CSR_ADDR_W = 12;

// one csr word
typedef logic [CSR_DATA_W-1:0] csr_data_t;

// full 64-bit counter, read as two words
typedef logic [2*CSR_DATA_W-1:0] csr_dword_t;

// csr address field of the instruction
typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

// ----------------------------------------------------------------------
// access operation
// low two bits of funct3 for csrrw/csrrs/csrrc

typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
} csr_op_t;

// ----------------------------------------------------------------------
// address map

// machine scratch
localparam csr_addr_t CSR_MSCRATCH = 12'h340;

// test harness mailbox
localparam csr_addr_t CSR_TOHOST = 12'h51E;

// machine counters, low halves
localparam csr_addr_t CSR_MCYCLE = 12'hB00;
localparam csr_addr_t CSR_MINSTRET = 12'hB02;

// machine counters, high halves
localparam csr_addr_t CSR_MCYCLEH = 12'hB80;
localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

// real-time counter, read only
localparam csr_addr_t CSR_TIME = 12'hC01;
localparam csr_addr_t CSR_TIMEH = 12'hC81;

endpackage

`default_nettype wire

// ==== logic/machine_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module machine_counters (
    input  logic clk,
    input  logic rst,
    input  logic retire_i,
    input  logic mcycle_lo_we_i,
    input  logic mcycle_hi_we_i,
    input  logic minstret_lo_we_i,
    input  logic minstret_hi_we_i,
    input  csr_pkg::csr_data_t wdata_i,
    output csr_pkg::csr_dword_t mcycle_o,
    output csr_pkg::csr_dword_t minstret_o
);

localparam int unsigned DW = csr_pkg::CSR_DATA_W;

csr_pkg::csr_dword_t mcycle_q;
csr_pkg::csr_dword_t minstret_q;

// a half write wins, the counter holds off for that cycle
function automatic csr_pkg::csr_dword_t next_count(
    input csr_pkg::csr_dword_t cur,
    input logic lo_we,
    input logic hi_we,
    input csr_pkg::csr_data_t data,
    input logic inc
);
    csr_pkg::csr_dword_t nxt;
    nxt = cur + csr_pkg::csr_dword_t'(inc);
    if (lo_we) begin
        nxt = {cur[2*DW-1:DW], data};
    end else if (hi_we) begin
        nxt = {data, cur[DW-1:0]};
    end
    return nxt;
endfunction

always_ff @(posedge clk) begin
    if (rst) begin
        mcycle_q <= '0;
        minstret_q <= '0;
    end else begin
        mcycle_q <= next_count(mcycle_q, mcycle_lo_we_i, mcycle_hi_we_i, wdata_i, 1'b1);
        minstret_q <= next_count(minstret_q, minstret_lo_we_i, minstret_hi_we_i,
                                 wdata_i, retire_i);
    end
end

assign mcycle_o = mcycle_q;
assign minstret_o = minstret_q;

endmodule

`default_nettype wire

// ==== logic/us_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module us_timer #(
    parameter int unsigned CLOCK_FREQ = 100_000_000 // Hz
)(
    input  logic clk,
    input  logic rst,
    output csr_pkg::csr_dword_t mtime_o
);

// ----------------------------------------------------------------------
// divider

localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ / 1_000_000;

// keep at least one bit for a 1 MHz clock
localparam int unsigned CNT_WIDTH = (CLOCKS_PER_US > 1) ? $clog2(CLOCKS_PER_US) : 1;

localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(CLOCKS_PER_US - 1);

logic [CNT_WIDTH-1:0] cnt_us;
logic tick_us;

// tick is high for the cycle after the last count
always_ff @(posedge clk) begin
    if (rst) begin
        cnt_us <= '0;
        tick_us <= 1'b0;
    end else if (cnt_us == CNT_LAST) begin
        cnt_us <= '0;
        tick_us <= 1'b1;
    end else begin
        cnt_us <= cnt_us + 1'b1;
        tick_us <= 1'b0;
    end
end

// ----------------------------------------------------------------------
// time counter

csr_pkg::csr_dword_t mtime_q;

always_ff @(posedge clk) begin
    if (rst) begin
        mtime_q <= '0;
    end else begin
        mtime_q <= mtime_q + csr_pkg::csr_dword_t'(tick_us);
    end
end

assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// ==== logic/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter int unsigned CLOCK_FREQ = 100_000_000 // Hz
)(
    input  logic clk,
    input  logic rst,
    input  logic csr_re_i,
    input  logic csr_we_i,
    input  csr_pkg::csr_op_t csr_op_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  csr_pkg::csr_data_t csr_wdata_i,
    input  logic retire_i,
    output csr_pkg::csr_data_t csr_rdata_o,
    output csr_pkg::csr_data_t tohost_o
);

localparam int unsigned DW = csr_pkg::CSR_DATA_W;

csr_pkg::csr_data_t tohost_q;
csr_pkg::csr_data_t mscratch_q;
csr_pkg::csr_data_t wdata;
csr_pkg::csr_dword_t mcycle;
csr_pkg::csr_dword_t minstret;
csr_pkg::csr_dword_t mtime;

// ----------------------------------------------------------------------
// address decode

logic sel_tohost;
logic sel_mscratch;
logic sel_mcycle;
logic sel_mcycleh;
logic sel_minstret;
logic sel_minstreth;
logic sel_time;
logic sel_timeh;

assign sel_tohost = (csr_addr_i == csr_pkg::CSR_TOHOST);
assign sel_mscratch = (csr_addr_i == csr_pkg::CSR_MSCRATCH);
assign sel_mcycle = (csr_addr_i == csr_pkg::CSR_MCYCLE);
assign sel_mcycleh = (csr_addr_i == csr_pkg::CSR_MCYCLEH);
assign sel_minstret = (csr_addr_i == csr_pkg::CSR_MINSTRET);
assign sel_minstreth = (csr_addr_i == csr_pkg::CSR_MINSTRETH);
assign sel_time = (csr_addr_i == csr_pkg::CSR_TIME);
assign sel_timeh = (csr_addr_i == csr_pkg::CSR_TIMEH);

// ----------------------------------------------------------------------
// read

// selects are one-hot, unknown address falls out as zero
always_comb begin
    csr_rdata_o = '0;
    if (csr_re_i) begin
        csr_rdata_o = ({DW{sel_tohost}} & tohost_q)
            | ({DW{sel_mscratch}} & mscratch_q)
            | ({DW{sel_mcycle}} & mcycle[DW-1:0])
            | ({DW{sel_mcycleh}} & mcycle[2*DW-1:DW])
            | ({DW{sel_minstret}} & minstret[DW-1:0])
            | ({DW{sel_minstreth}} & minstret[2*DW-1:DW])
            | ({DW{sel_time}} & mtime[DW-1:0])
            | ({DW{sel_timeh}} & mtime[2*DW-1:DW]);
    end
end

// ----------------------------------------------------------------------
// write

// set/clear work on the value seen on the read port
always_comb begin
    wdata = csr_wdata_i;
    case (csr_op_i)
        csr_pkg::CSR_OP_RW: wdata = csr_wdata_i;
        csr_pkg::CSR_OP_RS: wdata = csr_rdata_o | csr_wdata_i;
        csr_pkg::CSR_OP_RC: wdata = csr_rdata_o & ~csr_wdata_i;
        default: wdata = csr_wdata_i;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        tohost_q <= '0;
        mscratch_q <= '0;
    end else if (csr_we_i) begin
        if (sel_tohost) begin
            tohost_q <= wdata;
        end
        if (sel_mscratch) begin
            mscratch_q <= wdata;
        end
    end
end

assign tohost_o = tohost_q;

// ----------------------------------------------------------------------
// counters

machine_counters counters0 (
    .clk (clk),
    .rst (rst),
    .retire_i (retire_i),
    .mcycle_lo_we_i (csr_we_i && sel_mcycle),
    .mcycle_hi_we_i (csr_we_i && sel_mcycleh),
    .minstret_lo_we_i (csr_we_i && sel_minstret),
    .minstret_hi_we_i (csr_we_i && sel_minstreth),
    .wdata_i (wdata),
    .mcycle_o (mcycle),
    .minstret_o (minstret)
);

// time is read only, nothing to strobe
us_timer #(
    .CLOCK_FREQ (CLOCK_FREQ)
) timer0 (
    .clk (clk),
    .rst (rst),
    .mtime_o (mtime)
);

endmodule

`default_nettype wire

// ==== testbench/csr_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker (
    input logic clk,
    input logic rst,
    input logic csr_re_i,
    input logic csr_we_i,
    input csr_pkg::csr_data_t csr_rdata_i,
    input csr_pkg::csr_data_t tohost_i
);

// ----------------------------------------------------------------------
// read port idles at zero

rdata_zero_without_read: assert property (@(posedge clk) disable iff (rst)
    !csr_re_i |-> csr_rdata_i == '0)
    else $error("csr read data nonzero while read enable is low");

// tohost moves only after a write cycle
tohost_needs_write: assert property (@(posedge clk) disable iff (rst)
    !$stable(tohost_i) |-> $past(csr_we_i))
    else $error("tohost changed without a preceding write");

tohost_clear_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> tohost_i == '0)
    else $error("tohost not zero after reset");

endmodule

bind csr_unit csr_unit_checker checker0 (
    .clk (clk),
    .rst (rst),
    .csr_re_i (csr_re_i),
    .csr_we_i (csr_we_i),
    .csr_rdata_i (csr_rdata_o),
    .tohost_i (tohost_o)
);

`default_nettype wire

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

localparam int unsigned CLOCK_FREQ = 4_000_000;
localparam int CLOCKS_PER_US = 4;
localparam csr_pkg::csr_addr_t UNKNOWN_ADDR = 12'h7C0;

logic clk = 1'b0;
logic rst;
logic re;
logic we;
csr_pkg::csr_op_t op;
csr_pkg::csr_addr_t addr;
csr_pkg::csr_data_t wdata;
logic retire;
csr_pkg::csr_data_t rdata;
csr_pkg::csr_data_t tohost;

// reference model state
csr_pkg::csr_data_t m_tohost = '0;
csr_pkg::csr_data_t m_mscratch = '0;
csr_pkg::csr_dword_t m_mcycle = '0;
csr_pkg::csr_dword_t m_minstret = '0;
csr_pkg::csr_dword_t m_time = '0;
int m_div = 0;
logic m_tick = 1'b0;

logic [31:0] rng_state = 32'h3e70f52f;
int checks = 0;
int errors = 0;
int test_errors = 0;
logic check_en = 1'b0;
string cur_test = "none";

always #5 clk = ~clk;

csr_unit #(
    .CLOCK_FREQ (CLOCK_FREQ)
) dut0 (
    .clk (clk),
    .rst (rst),
    .csr_re_i (re),
    .csr_we_i (we),
    .csr_op_i (op),
    .csr_addr_i (addr),
    .csr_wdata_i (wdata),
    .retire_i (retire),
    .csr_rdata_o (rdata),
    .tohost_o (tohost)
);

// ----------------------------------------------------------------------
// helpers

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic csr_pkg::csr_op_t pick_op(input logic [1:0] sel);
    csr_pkg::csr_op_t o;
    case (sel)
        2'd0: o = csr_pkg::CSR_OP_RW;
        2'd1: o = csr_pkg::CSR_OP_RS;
        2'd2: o = csr_pkg::CSR_OP_RC;
        default: o = csr_pkg::CSR_OP_RS;
    endcase
    return o;
endfunction

// model value at an address or zero when unmapped
function automatic csr_pkg::csr_data_t model_read(input csr_pkg::csr_addr_t a);
    csr_pkg::csr_data_t v;
    case (a)
        csr_pkg::CSR_TOHOST: v = m_tohost;
        csr_pkg::CSR_MSCRATCH: v = m_mscratch;
        csr_pkg::CSR_MCYCLE: v = m_mcycle[31:0];
        csr_pkg::CSR_MCYCLEH: v = m_mcycle[63:32];
        csr_pkg::CSR_MINSTRET: v = m_minstret[31:0];
        csr_pkg::CSR_MINSTRETH: v = m_minstret[63:32];
        csr_pkg::CSR_TIME: v = m_time[31:0];
        csr_pkg::CSR_TIMEH: v = m_time[63:32];
        default: v = '0;
    endcase
    return v;
endfunction

function automatic csr_pkg::csr_data_t write_word(input csr_pkg::csr_op_t o,
                                                  input csr_pkg::csr_data_t rd,
                                                  input csr_pkg::csr_data_t d);
    csr_pkg::csr_data_t w;
    if (o == csr_pkg::CSR_OP_RS) begin
        w = rd | d;
    end else if (o == csr_pkg::CSR_OP_RC) begin
        w = rd & ~d;
    end else begin
        w = d;
    end
    return w;
endfunction

task automatic check_word(input string what, input csr_pkg::csr_data_t exp,
                          input csr_pkg::csr_data_t act);
    checks = checks + 1;
    if (act !== exp) begin
        errors = errors + 1;
        $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

// one access cycle that returns after the model has checked it
task automatic access(input logic r, input logic w, input csr_pkg::csr_op_t o,
                      input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t d,
                      input logic ret);
    @(posedge clk);
    re <= r;
    we <= w;
    op <= o;
    addr <= a;
    wdata <= d;
    retire <= ret;
    @(negedge clk);
    #1;
endtask

task automatic begin_test(input string name);
    cur_test = name;
    test_errors = errors;
endtask

task automatic end_test();
    $display("test %s: %0d errors", cur_test, errors - test_errors);
endtask

// ----------------------------------------------------------------------
// model checked and stepped between rising edges

always @(negedge clk) begin : model_step
    csr_pkg::csr_data_t exp_rd;
    csr_pkg::csr_data_t word;
    exp_rd = re ? model_read(addr) : '0;
    if (check_en) begin
        check_word("rdata", exp_rd, rdata);
        check_word("tohost_o", m_tohost, tohost);
    end
    if (rst) begin
        m_tohost = '0;
        m_mscratch = '0;
        m_mcycle = '0;
        m_minstret = '0;
        m_time = '0;
        m_div = 0;
        m_tick = 1'b0;
    end else begin
        word = write_word(op, exp_rd, wdata);
        m_time = m_time + {63'd0, m_tick};
        if (m_div == CLOCKS_PER_US - 1) begin
            m_div = 0;
            m_tick = 1'b1;
        end else begin
            m_div = m_div + 1;
            m_tick = 1'b0;
        end
        // a half write holds the counter for that cycle
        if (we && addr == csr_pkg::CSR_MCYCLE) begin
            m_mcycle[31:0] = word;
        end else if (we && addr == csr_pkg::CSR_MCYCLEH) begin
            m_mcycle[63:32] = word;
        end else begin
            m_mcycle = m_mcycle + 64'd1;
        end
        if (we && addr == csr_pkg::CSR_MINSTRET) begin
            m_minstret[31:0] = word;
        end else if (we && addr == csr_pkg::CSR_MINSTRETH) begin
            m_minstret[63:32] = word;
        end else begin
            m_minstret = m_minstret + {63'd0, retire};
        end
        if (we && addr == csr_pkg::CSR_TOHOST) begin
            m_tohost = word;
        end
        if (we && addr == csr_pkg::CSR_MSCRATCH) begin
            m_mscratch = word;
        end
    end
end

// ----------------------------------------------------------------------
// tests

initial begin : run
    int i;
    int k;
    int n;
    logic [31:0] r;
    csr_pkg::csr_data_t start;
    csr_pkg::csr_addr_t a;
    rst <= 1'b1;
    re <= 1'b0;
    we <= 1'b0;
    op <= csr_pkg::CSR_OP_RW;
    addr <= '0;
    wdata <= '0;
    retire <= 1'b0;
    for (i = 0; i < 10; i++) begin
        @(posedge clk);
    end
    rst <= 1'b0;
    check_en = 1'b1;

    begin_test("reset_state");
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_TOHOST, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSCRATCH, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRET, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRETH, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MCYCLE, '0, 1'b0);
    check_word("tohost_o at reset", '0, tohost);
    end_test();

    begin_test("set_clear");
    for (i = 0; i < 150; i++) begin
        r = next_rand();
        access(r[3], r[4] | r[5], pick_op(r[2:1]),
               r[0] ? csr_pkg::CSR_TOHOST : csr_pkg::CSR_MSCRATCH, next_rand(), r[6]);
    end
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_TOHOST, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSCRATCH, '0, 1'b0);
    end_test();

    begin_test("mcycle");
    for (i = 0; i < 100; i++) begin
        r = next_rand();
        access(1'b1, r[7:4] == 4'd0, csr_pkg::CSR_OP_RW,
               r[0] ? csr_pkg::CSR_MCYCLEH : csr_pkg::CSR_MCYCLE, next_rand(), r[3]);
    end
    end_test();

    begin_test("minstret");
    for (i = 0; i < 100; i++) begin
        r = next_rand();
        access(r[1] | r[2], r[7:5] == 3'd0, pick_op(r[9:8]),
               r[0] ? csr_pkg::CSR_MINSTRETH : csr_pkg::CSR_MINSTRET, next_rand(), r[3]);
    end
    // low half near all ones so the count carries into the high half
    access(1'b1, 1'b1, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRET, 32'hFFFF_FFFD, 1'b0);
    for (i = 0; i < 6; i++) begin
        access(1'b1, 1'b0, csr_pkg::CSR_OP_RW,
               i[0] ? csr_pkg::CSR_MINSTRET : csr_pkg::CSR_MINSTRETH, '0, 1'b1);
    end
    end_test();

    begin_test("time");
    for (k = 0; k < 3; k++) begin
        access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_TIME, '0, 1'b0);
        start = rdata;
        n = 0;
        while (rdata == start && n < 3 * CLOCKS_PER_US) begin
            access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_TIME, '0, 1'b0);
            n = n + 1;
        end
        if (rdata == start) begin
            errors = errors + 1;
            $display("time did not advance within %0d cycles", 3 * CLOCKS_PER_US);
        end
    end
    // write attempts on the read-only time halves and an unmapped address
    for (i = 0; i < 60; i++) begin
        r = next_rand();
        case (r[1:0])
            2'd1: a = csr_pkg::CSR_TIMEH;
            2'd2: a = UNKNOWN_ADDR;
            default: a = csr_pkg::CSR_TIME;
        endcase
        access(r[2] | r[3], r[4], pick_op(r[6:5]), a, next_rand(), r[7]);
    end
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, UNKNOWN_ADDR, '0, 1'b0);
    check_word("unknown address", '0, rdata);
    // the other registers kept their values
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSCRATCH, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MCYCLE, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MCYCLEH, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRET, '0, 1'b0);
    access(1'b1, 1'b0, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRETH, '0, 1'b0);
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
common/csr_pkg.sv
logic/machine_counters.sv
logic/us_timer.sv
logic/csr_unit.sv
testbench/csr_unit_checker.sv
testbench/csr_unit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f csr_unit.f --top-module csr_unit_tb \
		-Mdir obj_dir -o csr_unit_sim
	./obj_dir/csr_unit_sim > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
